// File: rtl/dpr_pkg.sv
`default_nettype none

// Datapath types shared by the operator bank and the result stage
package dpr_pkg;

  // Operand and result width
  localparam int DATA_W = 8;

  // Width of the operation select
  localparam int OPSEL_W = 5;

  typedef logic [DATA_W-1:0] data_t;

  // Operation codes, anything above OP_SUB yields zero
  typedef enum logic [OPSEL_W-1:0] {
    OP_ADD = 5'd0,
    OP_DEC = 5'd1,
    OP_DIV = 5'd2,
    OP_INC = 5'd3,
    OP_MOD = 5'd4,
    OP_MUL = 5'd5,
    OP_MUX = 5'd6,
    OP_REG = 5'd7,
    OP_SHL = 5'd8,
    OP_SHR = 5'd9,
    OP_SUB = 5'd10
  } opcode_e;

  // Both operands plus the 2:1 select level
  typedef struct packed {
    data_t a;
    data_t b;
    logic  mux_sel;
  } operands_t;

  // Magnitude comparator flags
  typedef struct packed {
    logic lt;
    logic gt;
    logic eq;
  } comp_t;

  // One result word per operator
  typedef struct packed {
    data_t add_r;
    data_t dec_r;
    data_t div_r;
    data_t inc_r;
    data_t mod_r;
    data_t mul_r;
    data_t mux_r;
    data_t reg_r;
    data_t shl_r;
    data_t shr_r;
    data_t sub_r;
  } op_results_t;

endpackage

`default_nettype wire

// File: rtl/rm_pkg.sv
`default_nettype none

// Reconfiguration control types and phase lengths
package rm_pkg;

  // Cycles the module reset is held on startup
  localparam int RM_RESET_CYCLES = 4;

  // Cycles spent decoupled before going idle on shutdown
  localparam int RM_DRAIN_CYCLES = 2;

  // Phase counter width, must hold the longer phase
  localparam int TIMER_W = 3;

  typedef enum logic [1:0] {
    RM_IDLE,
    RM_RESET,
    RM_ACTIVE,
    RM_DRAIN
  } rm_state_e;

  // Which phase the timer is asked to time
  typedef enum logic {
    PH_RESET,
    PH_DRAIN
  } phase_e;

  // Start is a single-cycle pulse
  typedef struct packed {
    logic   start;
    phase_e phase;
  } timer_cmd_t;

  // Status levels toward the reconfigurable module
  typedef struct packed {
    logic decouple;
    logic rm_reset;
    logic active;
  } rm_status_t;

endpackage

`default_nettype wire

// File: rtl/rm_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module rm_ctrl_fsm (
  input  wire                clk,
  input  wire                rst_n_i,
  input  logic               sw_startup_req_i,
  input  logic               sw_shutdown_req_i,
  input  logic               timer_done_i,
  output rm_pkg::timer_cmd_t timer_cmd_o,
  output rm_pkg::rm_status_t status_o
);

  rm_pkg::rm_state_e state_q;
  rm_pkg::rm_state_e state_d;

  // State register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= rm_pkg::RM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  // Requests outside their own state are dropped
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      rm_pkg::RM_IDLE: begin
        if (sw_startup_req_i) begin
          state_d = rm_pkg::RM_RESET;
        end
      end
      rm_pkg::RM_RESET: begin
        // Module reset held until the timer expires
        if (timer_done_i) begin
          state_d = rm_pkg::RM_ACTIVE;
        end
      end
      rm_pkg::RM_ACTIVE: begin
        if (sw_shutdown_req_i) begin
          state_d = rm_pkg::RM_DRAIN;
        end
      end
      rm_pkg::RM_DRAIN: begin
        if (timer_done_i) begin
          state_d = rm_pkg::RM_IDLE;
        end
      end
      default: begin
        state_d = rm_pkg::RM_IDLE;
      end
    endcase
  end

  // Timer kicked on the edge that enters RESET or DRAIN
  // so that its count starts together with the new state
  always_comb begin
    timer_cmd_o.start = 1'b0;
    timer_cmd_o.phase = rm_pkg::PH_RESET;
    if (state_q == rm_pkg::RM_IDLE && sw_startup_req_i) begin
      timer_cmd_o.start = 1'b1;
    end
    if (state_q == rm_pkg::RM_ACTIVE && sw_shutdown_req_i) begin
      timer_cmd_o.start = 1'b1;
      timer_cmd_o.phase = rm_pkg::PH_DRAIN;
    end
  end

  // Status levels decoded from the state
  always_comb begin
    unique case (state_q)
      rm_pkg::RM_ACTIVE: begin
        status_o = '{decouple: 1'b0, rm_reset: 1'b0, active: 1'b1};
      end
      rm_pkg::RM_DRAIN: begin
        // Outputs isolated, module keeps running out of reset
        status_o = '{decouple: 1'b1, rm_reset: 1'b0, active: 1'b0};
      end
      default: begin
        // Idle and reset phase, isolated and held in reset
        status_o = '{decouple: 1'b1, rm_reset: 1'b1, active: 1'b0};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rm_phase_timer.sv
`timescale 1ns/1ns
`default_nettype none

module rm_phase_timer (
  input  wire                clk,
  input  wire                rst_n_i,
  input  rm_pkg::timer_cmd_t cmd_i,
  output logic               done_o
);

  logic [rm_pkg::TIMER_W-1:0] count_q;
  logic [rm_pkg::TIMER_W-1:0] load_val;

  // Phase length picked by the command
  always_comb begin
    if (cmd_i.phase == rm_pkg::PH_DRAIN) begin
      load_val = rm_pkg::TIMER_W'(rm_pkg::RM_DRAIN_CYCLES);
    end else begin
      load_val = rm_pkg::TIMER_W'(rm_pkg::RM_RESET_CYCLES);
    end
  end

  // Down-counter, zero means idle
  // done pulses on the edge that moves the count from 1 to 0
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_q <= '0;
      done_o  <= 1'b0;
    end else if (cmd_i.start) begin
      // Restart drops any phase in progress
      count_q <= load_val;
      done_o  <= 1'b0;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
      done_o  <= (count_q == rm_pkg::TIMER_W'(1));
    end else begin
      done_o  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rm_op_bank.sv
`timescale 1ns/1ns
`default_nettype none

module rm_op_bank (
  input  dpr_pkg::operands_t   operands_i,
  input  dpr_pkg::data_t       reg_q_i,
  output dpr_pkg::op_results_t results_o,
  output dpr_pkg::comp_t       comp_o
);

  dpr_pkg::data_t             a;
  dpr_pkg::data_t             b;
  logic [2*dpr_pkg::DATA_W-1:0] prod;
  logic                       b_zero;
  logic                       sh_over;

  assign a = operands_i.a;
  assign b = operands_i.b;

  // Full product, only the low word is kept
  assign prod = a * b;

  assign b_zero = (b == '0);

  // Shift amounts of a full word or more clear the result
  assign sh_over = (b >= dpr_pkg::DATA_W);

  // Arithmetic, all wraps modulo 2^DATA_W
  assign results_o.add_r = a + b;
  assign results_o.sub_r = a - b;
  assign results_o.inc_r = a + 1'b1;
  assign results_o.dec_r = a - 1'b1;
  assign results_o.mul_r = prod[dpr_pkg::DATA_W-1:0];

  // Divide by zero saturates to all ones
  always_comb begin
    if (b_zero) begin
      results_o.div_r = '1;
    end else begin
      results_o.div_r = a / b;
    end
  end

  // Modulo by zero passes a through
  always_comb begin
    if (b_zero) begin
      results_o.mod_r = a;
    end else begin
      results_o.mod_r = a % b;
    end
  end

  // 2:1 select, b on mux_sel high
  assign results_o.mux_r = operands_i.mux_sel ? b : a;

  // Register operator state comes from the result stage
  assign results_o.reg_r = reg_q_i;

  // Logical shifts by b
  always_comb begin
    if (sh_over) begin
      results_o.shl_r = '0;
      results_o.shr_r = '0;
    end else begin
      results_o.shl_r = a << b;
      results_o.shr_r = a >> b;
    end
  end

  // Magnitude comparator, unsigned
  assign comp_o.lt = (a < b);
  assign comp_o.gt = (a > b);
  assign comp_o.eq = (a == b);

endmodule

`default_nettype wire

// File: rtl/rm_result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rm_result_stage (
  input  wire                clk,
  input  wire                rst_n_i,
  input  dpr_pkg::operands_t operands_i,
  input  dpr_pkg::opcode_e   op_sel_i,
  input  rm_pkg::rm_status_t status_i,
  output dpr_pkg::data_t     result_o,
  output dpr_pkg::comp_t     comp_o
);

  dpr_pkg::operands_t   ops_q;
  dpr_pkg::opcode_e     opsel_q;
  dpr_pkg::data_t       reg_q;
  dpr_pkg::op_results_t results;
  dpr_pkg::comp_t       comp;
  dpr_pkg::data_t       result_sel;
  dpr_pkg::data_t       result_q;
  dpr_pkg::comp_t       comp_q;

  // First stage, operands and opcode sampled every cycle
  always_ff @(posedge clk) begin
    ops_q   <= operands_i;
    opsel_q <= op_sel_i;
  end

  // Register operator
  // holds a from one sample before the current operands
  // cleared while the module sits in reset
  always_ff @(posedge clk) begin
    if (!rst_n_i || status_i.rm_reset) begin
      reg_q <= '0;
    end else begin
      reg_q <= ops_q.a;
    end
  end

  rm_op_bank i_op_bank (
    .operands_i (ops_q),
    .reg_q_i    (reg_q),
    .results_o  (results),
    .comp_o     (comp)
  );

  // Pick one operator by the registered opcode
  always_comb begin
    case (opsel_q)
      dpr_pkg::OP_ADD: result_sel = results.add_r;
      dpr_pkg::OP_DEC: result_sel = results.dec_r;
      dpr_pkg::OP_DIV: result_sel = results.div_r;
      dpr_pkg::OP_INC: result_sel = results.inc_r;
      dpr_pkg::OP_MOD: result_sel = results.mod_r;
      dpr_pkg::OP_MUL: result_sel = results.mul_r;
      dpr_pkg::OP_MUX: result_sel = results.mux_r;
      dpr_pkg::OP_REG: result_sel = results.reg_r;
      dpr_pkg::OP_SHL: result_sel = results.shl_r;
      dpr_pkg::OP_SHR: result_sel = results.shr_r;
      dpr_pkg::OP_SUB: result_sel = results.sub_r;
      // Unused codes
      default:         result_sel = '0;
    endcase
  end

  // Second stage, result and flags
  always_ff @(posedge clk) begin
    result_q <= result_sel;
    comp_q   <= comp;
  end

  // Isolation from the static side while decoupled
  assign result_o = status_i.decouple ? '0 : result_q;
  assign comp_o   = status_i.decouple ? '0 : comp_q;

endmodule

`default_nettype wire

// File: rtl/dpr_top.sv
`timescale 1ns/1ns
`default_nettype none

module dpr_top (
  input  wire                clk,
  input  wire                rst_n_i,
  input  dpr_pkg::operands_t operands_i,
  input  dpr_pkg::opcode_e   op_sel_i,
  input  logic               sw_startup_req_i,
  input  logic               sw_shutdown_req_i,
  output dpr_pkg::data_t     result_o,
  output dpr_pkg::comp_t     comp_o,
  output rm_pkg::rm_status_t rm_status_o
);

  rm_pkg::timer_cmd_t timer_cmd;
  logic               timer_done;
  rm_pkg::rm_status_t status;

  // Reconfiguration sequencer
  rm_ctrl_fsm i_ctrl_fsm (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .sw_startup_req_i  (sw_startup_req_i),
    .sw_shutdown_req_i (sw_shutdown_req_i),
    .timer_done_i      (timer_done),
    .timer_cmd_o       (timer_cmd),
    .status_o          (status)
  );

  // Reset and drain phase timing
  rm_phase_timer i_phase_timer (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cmd_i   (timer_cmd),
    .done_o  (timer_done)
  );

  // Operator datapath, two stages
  rm_result_stage i_result_stage (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .operands_i (operands_i),
    .op_sel_i   (op_sel_i),
    .status_i   (status),
    .result_o   (result_o),
    .comp_o     (comp_o)
  );

  assign rm_status_o = status;

endmodule

`default_nettype wire

// File: tb/dpr_top_props.sv
`timescale 1ns/1ns
`default_nettype none

module dpr_top_props (
  input wire                clk,
  input wire                rst_n_i,
  input logic               sw_startup_req_i,
  input rm_pkg::rm_state_e  state_q,
  input rm_pkg::rm_status_t status_o
);

  // Isolation lifted only together with active
  a_decouple_when_inactive: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !status_o.active |-> status_o.decouple
  ) else $error("decouple dropped while the module is not active");

  // Honored startup, active rises RM_RESET_CYCLES+1 edges later
  // and shows in the sampled value one tick after that edge
  a_startup_to_active: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state_q == rm_pkg::RM_IDLE && sw_startup_req_i)
      |=> ##(rm_pkg::RM_RESET_CYCLES + 1) $rose(status_o.active)
  ) else $error("active did not rise on time after a startup request");

  // Never running while held in reset
  a_active_excludes_reset: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(status_o.active && status_o.rm_reset)
  ) else $error("active and module reset asserted together");

endmodule

bind rm_ctrl_fsm dpr_top_props i_props (
  .clk              (clk),
  .rst_n_i          (rst_n_i),
  .sw_startup_req_i (sw_startup_req_i),
  .state_q          (state_q),
  .status_o         (status_o)
);

`default_nettype wire

// File: tb/dpr_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dpr_top_tb;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_LEN  = 8;
  localparam int MAX_ITEMS  = 128;
  localparam int N_IDLE     = 6;
  localparam int N_PER_OP   = 6;
  localparam int N_COMP     = 40;
  localparam int N_EDGE     = 18;
  // One startup or shutdown sequence plus its request pulse and spare edges
  localparam int SEQ_LEN    = rm_pkg::RM_RESET_CYCLES + rm_pkg::RM_DRAIN_CYCLES + 10;
  // Four item runs with two edges of pipeline flush each
  localparam int ITEM_LEN   = N_IDLE + 11 * N_PER_OP + 21 + N_COMP + 4 + N_EDGE + 4 * 2;
  localparam int RUN_LEN    = RESET_LEN + 7 * SEQ_LEN + ITEM_LEN;
  localparam int WATCHDOG_NS = 2 * RUN_LEN * CLK_PERIOD;

  localparam rm_pkg::rm_status_t ST_HELD   = '{decouple: 1'b1, rm_reset: 1'b1, active: 1'b0};
  localparam rm_pkg::rm_status_t ST_ACTIVE = '{decouple: 1'b0, rm_reset: 1'b0, active: 1'b1};
  localparam rm_pkg::rm_status_t ST_DRAIN  = '{decouple: 1'b1, rm_reset: 1'b0, active: 1'b0};

  logic               clk;
  logic               rst_n;
  dpr_pkg::operands_t operands;
  dpr_pkg::opcode_e   op_sel;
  logic               sw_startup_req;
  logic               sw_shutdown_req;
  dpr_pkg::data_t     result;
  dpr_pkg::comp_t     comp;
  rm_pkg::rm_status_t rm_status;

  // Pending items of the current test
  dpr_pkg::operands_t          item_ops  [MAX_ITEMS];
  logic [dpr_pkg::OPSEL_W-1:0] item_code [MAX_ITEMS];
  int                          n_items;

  int n_checks;
  int data_errors;
  int comp_errors;
  int status_errors;

  dpr_top i_dut (
    .clk               (clk),
    .rst_n_i           (rst_n),
    .operands_i        (operands),
    .op_sel_i          (op_sel),
    .sw_startup_req_i  (sw_startup_req),
    .sw_shutdown_req_i (sw_shutdown_req),
    .result_o          (result),
    .comp_o            (comp),
    .rm_status_o       (rm_status)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_data(input string name, input dpr_pkg::data_t got,
                            input dpr_pkg::data_t exp);
    n_checks++;
    if (got !== exp) begin
      data_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_comp(input string name, input dpr_pkg::comp_t got,
                            input dpr_pkg::comp_t exp);
    n_checks++;
    if (got !== exp) begin
      comp_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_status(input string name, input rm_pkg::rm_status_t got,
                              input rm_pkg::rm_status_t exp);
    n_checks++;
    if (got !== exp) begin
      status_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Reference model of the operators on unsigned values modulo 256
  function automatic dpr_pkg::data_t expected_result(input dpr_pkg::operands_t ops,
      input logic [dpr_pkg::OPSEL_W-1:0] code, input dpr_pkg::data_t older_a);
    int unsigned ua;
    int unsigned ub;
    int unsigned wide;
    ua   = ops.a;
    ub   = ops.b;
    wide = 0;
    case (code)
      dpr_pkg::OP_ADD: wide = ua + ub;
      dpr_pkg::OP_DEC: wide = ua + 256 - 1;
      dpr_pkg::OP_DIV: wide = (ub == 0) ? 255 : ua / ub;
      dpr_pkg::OP_INC: wide = ua + 1;
      dpr_pkg::OP_MOD: wide = (ub == 0) ? ua : ua % ub;
      dpr_pkg::OP_MUL: wide = ua * ub;
      dpr_pkg::OP_MUX: wide = ops.mux_sel ? ub : ua;
      dpr_pkg::OP_REG: wide = older_a;
      dpr_pkg::OP_SHL: wide = (ub >= 8) ? 0 : ua << ub;
      dpr_pkg::OP_SHR: wide = (ub >= 8) ? 0 : ua >> ub;
      dpr_pkg::OP_SUB: wide = ua + 256 - ub;
      default:         wide = 0;
    endcase
    return dpr_pkg::data_t'(wide % 256);
  endfunction

  // Exactly one flag set by the ordering of a and b
  function automatic dpr_pkg::comp_t expected_flags(input dpr_pkg::operands_t ops);
    dpr_pkg::comp_t flags;
    flags = '0;
    if (ops.a < ops.b) begin
      flags.lt = 1'b1;
    end else if (ops.a > ops.b) begin
      flags.gt = 1'b1;
    end else begin
      flags.eq = 1'b1;
    end
    return flags;
  endfunction

  function automatic dpr_pkg::operands_t make_operands(input dpr_pkg::data_t a,
      input dpr_pkg::data_t b, input logic sel);
    dpr_pkg::operands_t ops;
    ops.a       = a;
    ops.b       = b;
    ops.mux_sel = sel;
    return ops;
  endfunction

  function automatic dpr_pkg::operands_t random_operands();
    dpr_pkg::operands_t ops;
    ops.a       = dpr_pkg::data_t'($urandom);
    ops.b       = dpr_pkg::data_t'($urandom);
    ops.mux_sel = 1'($urandom);
    return ops;
  endfunction

  task automatic add_item(input dpr_pkg::operands_t ops,
                          input logic [dpr_pkg::OPSEL_W-1:0] code);
    item_ops[n_items]  = ops;
    item_code[n_items] = code;
    n_items++;
  endtask

  // One item per edge and each checked two edges after it is sampled
  task automatic run_items(input bit decoupled);
    dpr_pkg::data_t older_a [MAX_ITEMS];
    dpr_pkg::data_t exp_data;
    dpr_pkg::comp_t exp_comp;
    int             i;
    // Item 0 follows the level already on the operand bus
    older_a[0] = operands.a;
    for (i = 1; i < n_items; i++) begin
      older_a[i] = item_ops[i-1].a;
    end
    for (i = 0; i < n_items + 2; i++) begin
      @(posedge clk);
      if (i < n_items) begin
        operands <= item_ops[i];
        op_sel   <= dpr_pkg::opcode_e'(item_code[i]);
      end
      @(negedge clk);
      if (i >= 2) begin
        exp_data = '0;
        exp_comp = '0;
        if (!decoupled) begin
          exp_data = expected_result(item_ops[i-2], item_code[i-2], older_a[i-2]);
          exp_comp = expected_flags(item_ops[i-2]);
        end
        check_data("result_o", result, exp_data);
        check_comp("comp_o", comp, exp_comp);
      end
    end
    n_items = 0;
  endtask

  // Single-cycle request that returns on the edge sampling it
  task automatic pulse_request(input bit is_shutdown);
    @(posedge clk);
    if (is_shutdown) begin
      sw_shutdown_req <= 1'b1;
    end else begin
      sw_startup_req <= 1'b1;
    end
    @(posedge clk);
    sw_shutdown_req <= 1'b0;
    sw_startup_req  <= 1'b0;
  endtask

  // Status held for a number of edges and then the settled status
  task automatic expect_phase(input rm_pkg::rm_status_t during, input int edges,
                              input rm_pkg::rm_status_t after);
    repeat (edges) begin
      @(negedge clk);
      check_status("rm_status_o", rm_status, during);
      @(posedge clk);
    end
    @(negedge clk);
    check_status("rm_status_o", rm_status, after);
  endtask

  task automatic test_reset_state();
    check_status("rm_status_o", rm_status, ST_HELD);
    repeat (N_IDLE) begin
      add_item(random_operands(), 5'($urandom_range(0, 10)));
    end
    // Outputs isolated until startup
    run_items(1'b1);
    check_status("rm_status_o", rm_status, ST_HELD);
  endtask

  task automatic test_startup_shutdown();
    // Shutdown while idle is ignored
    pulse_request(1'b1);
    expect_phase(ST_HELD, 3, ST_HELD);
    pulse_request(1'b0);
    expect_phase(ST_HELD, rm_pkg::RM_RESET_CYCLES + 1, ST_ACTIVE);
    // Startup while active is ignored
    pulse_request(1'b0);
    expect_phase(ST_ACTIVE, 3, ST_ACTIVE);
    pulse_request(1'b1);
    expect_phase(ST_DRAIN, rm_pkg::RM_DRAIN_CYCLES + 1, ST_HELD);
    // Back up for the datapath tests
    pulse_request(1'b0);
    expect_phase(ST_HELD, rm_pkg::RM_RESET_CYCLES + 1, ST_ACTIVE);
  endtask

  task automatic test_operators();
    int code;
    for (code = 0; code <= 10; code++) begin
      repeat (N_PER_OP) begin
        add_item(random_operands(), 5'(code));
      end
    end
    // Unused codes
    for (code = 11; code < 32; code++) begin
      add_item(random_operands(), 5'(code));
    end
    run_items(1'b0);
  endtask

  task automatic test_comparator();
    dpr_pkg::operands_t ops;
    int                 i;
    add_item(make_operands(8'h00, 8'hff, 1'b0), dpr_pkg::OP_ADD);
    add_item(make_operands(8'hff, 8'h00, 1'b0), dpr_pkg::OP_SUB);
    add_item(make_operands(8'h00, 8'h00, 1'b0), dpr_pkg::OP_MUL);
    add_item(make_operands(8'hff, 8'hff, 1'b1), dpr_pkg::OP_MUX);
    for (i = 0; i < N_COMP; i++) begin
      ops = random_operands();
      // Every third pair equal
      if (i % 3 == 0) begin
        ops.b = ops.a;
      end
      add_item(ops, 5'($urandom_range(0, 10)));
    end
    run_items(1'b0);
  endtask

  task automatic test_edge_cases();
    add_item(make_operands(8'h9c, 8'h00, 1'b0), dpr_pkg::OP_DIV);
    add_item(make_operands(8'h00, 8'h00, 1'b0), dpr_pkg::OP_DIV);
    add_item(make_operands(8'h64, 8'h07, 1'b0), dpr_pkg::OP_DIV);
    add_item(make_operands(8'h9c, 8'h00, 1'b0), dpr_pkg::OP_MOD);
    add_item(make_operands(8'hff, 8'h00, 1'b0), dpr_pkg::OP_MOD);
    add_item(make_operands(8'h64, 8'h07, 1'b0), dpr_pkg::OP_MOD);
    add_item(make_operands(8'ha5, 8'h07, 1'b0), dpr_pkg::OP_SHL);
    add_item(make_operands(8'ha5, 8'h08, 1'b0), dpr_pkg::OP_SHL);
    add_item(make_operands(8'ha5, 8'h09, 1'b0), dpr_pkg::OP_SHL);
    add_item(make_operands(8'ha5, 8'hff, 1'b0), dpr_pkg::OP_SHL);
    add_item(make_operands(8'ha5, 8'h07, 1'b0), dpr_pkg::OP_SHR);
    add_item(make_operands(8'ha5, 8'h08, 1'b0), dpr_pkg::OP_SHR);
    add_item(make_operands(8'ha5, 8'h80, 1'b0), dpr_pkg::OP_SHR);
    // Register operator trails a by one sample
    add_item(make_operands(8'h11, 8'h01, 1'b0), dpr_pkg::OP_REG);
    add_item(make_operands(8'h22, 8'h02, 1'b0), dpr_pkg::OP_REG);
    add_item(make_operands(8'h33, 8'h03, 1'b1), dpr_pkg::OP_REG);
    add_item(make_operands(8'h12, 8'h34, 1'b1), dpr_pkg::OP_MUX);
    add_item(make_operands(8'h12, 8'h34, 1'b0), dpr_pkg::OP_MUX);
    run_items(1'b0);
    // Hold a through a restart so stale state would show 0x5a
    @(posedge clk);
    operands <= make_operands(8'h5a, 8'h03, 1'b0);
    op_sel   <= dpr_pkg::OP_REG;
    pulse_request(1'b1);
    expect_phase(ST_DRAIN, rm_pkg::RM_DRAIN_CYCLES + 1, ST_HELD);
    pulse_request(1'b0);
    expect_phase(ST_HELD, rm_pkg::RM_RESET_CYCLES + 1, ST_ACTIVE);
    check_data("result_o", result, 8'h00);
    // Refilled once the module is out of reset
    repeat (2) @(negedge clk);
    check_data("result_o", result, 8'h5a);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(51));
    clk             = 1'b0;
    rst_n           = 1'b0;
    operands        = '0;
    op_sel          = dpr_pkg::OP_ADD;
    sw_startup_req  = 1'b0;
    sw_shutdown_req = 1'b0;
    n_items         = 0;
    n_checks        = 0;
    data_errors     = 0;
    comp_errors     = 0;
    status_errors   = 0;
    repeat (RESET_LEN) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset_state();
    test_startup_shutdown();
    test_operators();
    test_comparator();
    test_edge_cases();
    $display("checks %0d, result errors %0d, flag errors %0d, status errors %0d",
             n_checks, data_errors, comp_errors, status_errors);
    if (data_errors + comp_errors + status_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/dpr_pkg.sv
rtl/rm_pkg.sv
rtl/rm_ctrl_fsm.sv
rtl/rm_phase_timer.sv
rtl/rm_op_bank.sv
rtl/rm_result_stage.sv
rtl/dpr_top.sv
tb/dpr_top_props.sv
tb/dpr_top_tb.sv
